// ==== common/soc_consts.svh ====
//////////////////////////////////////////////////
// soc constants
// address map, register offsets, widths and sizes
//////////////////////////////////////////////////
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// bus widths
`define SOC_ADDR_W      12
`define SOC_DATA_W      32
`define SOC_OFS_W       4

// peripheral sizes
`define SOC_GPIO_W      12
`define SOC_IRQ_TOTAL   16
`define SOC_FIFO_DEPTH  4
`define SOC_RST_HOLD    8

// region field in address bits 11..8
`define SOC_BASE_GPIO   4'h0
`define SOC_BASE_CLINT  4'h1
`define SOC_BASE_PLIC   4'h2
`define SOC_BASE_SYS    4'hf

// gpio register offsets
`define SOC_GPIO_IN     4'h0
`define SOC_GPIO_OUT    4'h1
`define SOC_GPIO_DIR    4'h2
`define SOC_GPIO_IE     4'h3
`define SOC_GPIO_IP     4'h4

// clint register offsets
`define SOC_CLINT_MTIME     4'h0
`define SOC_CLINT_MTIMECMP  4'h1
`define SOC_CLINT_MSIP      4'h2

// plic register offsets
`define SOC_PLIC_PENDING  4'h0
`define SOC_PLIC_ENABLE   4'h1
`define SOC_PLIC_CLAIM    4'h2

// system control
`define SOC_SYS_SWRST   4'h0
`define SOC_SWRST_KEY   32'h5a5a_c3c3

`endif

// ==== common/soc_pkg.sv ====
//////////////////////////////////////////////////
// soc types
// host request, response and peripheral access
// structs, plus decode and bus controller enums
//////////////////////////////////////////////////
`default_nettype none
`include "soc_consts.svh"

package soc_pkg;

  // one host request as it enters the queue
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
  } host_req_t;

  // response back to the host, one per request
  typedef struct packed {
    logic                   valid;
    logic                   err;
    logic [`SOC_DATA_W-1:0] rdata;
  } bus_rsp_t;

  // access strobes toward a single peripheral
  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic [`SOC_OFS_W-1:0]  offset;
    logic [`SOC_DATA_W-1:0] wdata;
  } periph_req_t;

  // decoded target of the address
  typedef enum logic [2:0] {
    REG_GPIO,
    REG_CLINT,
    REG_PLIC,
    REG_SYS,
    REG_NONE
  } region_e;

  // bus controller states
  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } bus_state_e;

endpackage

`default_nettype wire

// ==== rtl/reset_global.sv ====
//////////////////////////////////////////////////
// global reset
// merges external reset with the software reset
// request and holds the system reset low
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module reset_global (
  input  wire  i_clk,
  input  wire  i_rst_n,
  input  wire  i_swreset,
  output logic o_sys_rst_n
);

  localparam int CW = $clog2(`SOC_RST_HOLD + 1);

  // remaining hold cycles after the first low one
  logic [CW-1:0] hold_cnt;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      hold_cnt    <= '0;
      o_sys_rst_n <= 1'b0;
    end else begin
      // request restarts the hold
      if (i_swreset) begin
        hold_cnt <= CW'(`SOC_RST_HOLD - 1);
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      o_sys_rst_n <= !i_swreset && (hold_cnt == '0);
    end
  end

endmodule

`default_nettype wire

// ==== bus/bus_req_fifo.sv ====
//////////////////////////////////////////////////
// bus request fifo
// circular buffer of host requests in front of
// the bus controller, registered full and empty
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module bus_req_fifo #(
  parameter int DEPTH = `SOC_FIFO_DEPTH
) (
  input  wire                i_clk,
  input  wire                i_rst_n,
  input  wire                soc_pkg::host_req_t i_req,
  input  wire                i_pop,
  output soc_pkg::host_req_t o_head,
  output logic               o_full
);

  // depth is a power of two so pointers wrap by themselves
  localparam int PW = $clog2(DEPTH);

  soc_pkg::host_req_t mem [DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count_q;
  logic [PW:0]   count_nxt;
  logic          empty_q;
  logic          push;
  logic          pop;

  // strobes while full are dropped
  assign push      = i_req.valid && !o_full;
  assign pop       = i_pop && !empty_q;
  assign count_nxt = count_q + (PW+1)'(push) - (PW+1)'(pop);

  ////////////////////////////////////////////////
  // pointers and occupancy
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
      o_full  <= 1'b0;
      empty_q <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count_q <= count_nxt;
      o_full  <= (count_nxt == (PW+1)'(DEPTH));
      empty_q <= (count_nxt == '0);
    end
  end

  // storage
  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_req;
    end
  end

  // head entry, valid means not empty
  always_comb begin
    o_head       = mem[rd_ptr];
    o_head.valid = !empty_q;
  end

endmodule

`default_nettype wire

// ==== bus/bus_ctrl.sv ====
//////////////////////////////////////////////////
// bus controller
// takes requests from the fifo, decodes the region,
// strobes one peripheral and returns the response
// also holds the system control register
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module bus_ctrl (
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire                  soc_pkg::host_req_t i_head,
  output logic                 o_pop,
  output soc_pkg::periph_req_t o_gpio_req,
  output soc_pkg::periph_req_t o_clint_req,
  output soc_pkg::periph_req_t o_plic_req,
  input  wire [31:0]           i_gpio_rdata,
  input  wire [31:0]           i_clint_rdata,
  input  wire [31:0]           i_plic_rdata,
  output logic                 o_swreset,
  output soc_pkg::bus_rsp_t    o_rsp
);

  soc_pkg::bus_state_e state_q;
  soc_pkg::region_e    region;
  soc_pkg::host_req_t  cur_q;

  logic [3:0]  ofs;
  logic        in_addr;
  logic        sel_gpio;
  logic        sel_clint;
  logic        sel_plic;
  logic        key_wr;
  logic [31:0] rd_mux;
  logic        err_mux;
  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic [31:0] rsp_data_q;

  // take the head only from idle
  assign o_pop = (state_q == soc_pkg::S_IDLE) && i_head.valid;
  assign ofs   = cur_q.addr[3:0];

  ////////////////////////////////////////////////
  // region decode on address bits 11..8
  always_comb begin
    case (cur_q.addr[11:8])
      `SOC_BASE_GPIO:  region = soc_pkg::REG_GPIO;
      `SOC_BASE_CLINT: region = soc_pkg::REG_CLINT;
      `SOC_BASE_PLIC:  region = soc_pkg::REG_PLIC;
      `SOC_BASE_SYS:   region = soc_pkg::REG_SYS;
      default:         region = soc_pkg::REG_NONE;
    endcase
  end

  // strobe only in the address phase
  assign in_addr   = (state_q == soc_pkg::S_ADDR);
  assign sel_gpio  = in_addr && (region == soc_pkg::REG_GPIO);
  assign sel_clint = in_addr && (region == soc_pkg::REG_CLINT);
  assign sel_plic  = in_addr && (region == soc_pkg::REG_PLIC);

  assign o_gpio_req  = '{rd: sel_gpio && !cur_q.we, wr: sel_gpio && cur_q.we,
                         offset: ofs, wdata: cur_q.wdata};
  assign o_clint_req = '{rd: sel_clint && !cur_q.we, wr: sel_clint && cur_q.we,
                         offset: ofs, wdata: cur_q.wdata};
  assign o_plic_req  = '{rd: sel_plic && !cur_q.we, wr: sel_plic && cur_q.we,
                         offset: ofs, wdata: cur_q.wdata};

  // reset only on the exact key
  assign key_wr = in_addr && (region == soc_pkg::REG_SYS) && cur_q.we &&
                  (ofs == `SOC_SYS_SWRST) && (cur_q.wdata == `SOC_SWRST_KEY);

  // read data select where sys and unmapped regions read as zero
  always_comb begin
    rd_mux  = '0;
    err_mux = 1'b0;
    case (region)
      soc_pkg::REG_GPIO:  rd_mux = i_gpio_rdata;
      soc_pkg::REG_CLINT: rd_mux = i_clint_rdata;
      soc_pkg::REG_PLIC:  rd_mux = i_plic_rdata;
      soc_pkg::REG_SYS:   err_mux = (ofs != `SOC_SYS_SWRST);
      default:            err_mux = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////
  // idle -> addr -> data -> idle
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q     <= soc_pkg::S_IDLE;
      rsp_valid_q <= 1'b0;
      o_swreset   <= 1'b0;
    end else begin
      case (state_q)
        soc_pkg::S_IDLE: begin
          if (i_head.valid) begin
            state_q <= soc_pkg::S_ADDR;
          end
        end
        soc_pkg::S_ADDR: state_q <= soc_pkg::S_DATA;
        default:         state_q <= soc_pkg::S_IDLE;
      endcase
      // one response pulse per request
      rsp_valid_q <= (state_q == soc_pkg::S_DATA);
      o_swreset   <= key_wr;
    end
  end

  // latched request and sampled read data
  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      cur_q <= i_head;
    end
    if (in_addr) begin
      rsp_err_q  <= err_mux;
      rsp_data_q <= rd_mux;
    end
  end

  assign o_rsp = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rsp_data_q};

endmodule

`default_nettype wire

// ==== rtl/gpio_ctrl.sv ====
//////////////////////////////////////////////////
// gpio controller
// output, direction and interrupt enable registers,
// synchronized inputs with rising edge pending bits
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module gpio_ctrl (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    soc_pkg::periph_req_t i_req,
  output logic [31:0]            o_rdata,
  input  wire  [`SOC_GPIO_W-1:0] i_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio_dir,
  output logic [`SOC_GPIO_W-1:0] o_irq
);

  localparam int W = `SOC_GPIO_W;

  logic [W-1:0] in_meta;
  logic [W-1:0] in_sync;
  logic [W-1:0] in_prev;
  logic [W-1:0] out_q;
  logic [W-1:0] dir_q;
  logic [W-1:0] ie_q;
  logic [W-1:0] ip_q;
  logic [W-1:0] rise;
  logic [W-1:0] ip_clr;

  assign rise   = in_sync & ~in_prev;
  // write one to clear
  assign ip_clr = (i_req.wr && (i_req.offset == `SOC_GPIO_IP)) ? i_req.wdata[W-1:0] : '0;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      in_meta <= '0;
      in_sync <= '0;
      in_prev <= '0;
      out_q   <= '0;
      dir_q   <= '0;
      ie_q    <= '0;
      ip_q    <= '0;
    end else begin
      // two flop synchronizer plus edge history
      in_meta <= i_gpio;
      in_sync <= in_meta;
      in_prev <= in_sync;
      if (i_req.wr) begin
        case (i_req.offset)
          `SOC_GPIO_OUT: out_q <= i_req.wdata[W-1:0];
          `SOC_GPIO_DIR: dir_q <= i_req.wdata[W-1:0];
          `SOC_GPIO_IE:  ie_q  <= i_req.wdata[W-1:0];
          default:       ;
        endcase
      end
      ip_q <= (ip_q & ~ip_clr) | (rise & ie_q);
    end
  end

  // register read mux
  always_comb begin
    o_rdata = '0;
    if (i_req.rd) begin
      case (i_req.offset)
        `SOC_GPIO_IN:  o_rdata[W-1:0] = in_sync;
        `SOC_GPIO_OUT: o_rdata[W-1:0] = out_q;
        `SOC_GPIO_DIR: o_rdata[W-1:0] = dir_q;
        `SOC_GPIO_IE:  o_rdata[W-1:0] = ie_q;
        `SOC_GPIO_IP:  o_rdata[W-1:0] = ip_q;
        default:       o_rdata = '0;
      endcase
    end
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;
  assign o_irq      = ip_q;

endmodule

`default_nettype wire

// ==== rtl/clint.sv ====
//////////////////////////////////////////////////
// core local interrupt controller
// free running machine timer with compare,
// plus the software interrupt register
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module clint (
  input  wire         i_clk,
  input  wire         i_rst_n,
  input  wire         soc_pkg::periph_req_t i_req,
  output logic [31:0] o_rdata,
  output logic        o_mtip,
  output logic        o_msip
);

  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic        msip_q;
  logic        wr_mtime;
  logic        wr_cmp;
  logic        wr_msip;

  assign wr_mtime = i_req.wr && (i_req.offset == `SOC_CLINT_MTIME);
  assign wr_cmp   = i_req.wr && (i_req.offset == `SOC_CLINT_MTIMECMP);
  assign wr_msip  = i_req.wr && (i_req.offset == `SOC_CLINT_MSIP);

  ////////////////////////////////////////////////
  // timer and compare
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mtime_q    <= '0;
      // compare at max keeps mtip quiet
      mtimecmp_q <= '1;
      o_mtip     <= 1'b0;
    end else begin
      if (wr_mtime) begin
        mtime_q <= i_req.wdata;
      end else begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr_cmp) begin
        mtimecmp_q <= i_req.wdata;
      end
      o_mtip <= (mtime_q >= mtimecmp_q);
    end
  end

  // software interrupt, bit 0 only
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      msip_q <= 1'b0;
    end else if (wr_msip) begin
      msip_q <= i_req.wdata[0];
    end
  end

  assign o_msip = msip_q;

  // register read mux
  always_comb begin
    o_rdata = '0;
    if (i_req.rd) begin
      case (i_req.offset)
        `SOC_CLINT_MTIME:    o_rdata = mtime_q;
        `SOC_CLINT_MTIMECMP: o_rdata = mtimecmp_q;
        `SOC_CLINT_MSIP:     o_rdata = {31'd0, msip_q};
        default:             o_rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/plic.sv ====
//////////////////////////////////////////////////
// platform level interrupt controller
// edge pending bits, enables and claim over the
// sources, drives the machine external interrupt
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module plic (
  input  wire                       i_clk,
  input  wire                       i_rst_n,
  input  wire                       soc_pkg::periph_req_t i_req,
  input  wire  [`SOC_IRQ_TOTAL-1:0] i_irq,
  output logic [31:0]               o_rdata,
  output logic                      o_meip
);

  localparam int N  = `SOC_IRQ_TOTAL;
  localparam int IW = $clog2(N);

  logic [N-1:0]  irq_prev;
  logic [N-1:0]  pend_q;
  logic [N-1:0]  en_q;
  logic [N-1:0]  rise;
  logic [N-1:0]  active;
  logic [N-1:0]  claim_clr;
  logic [IW-1:0] claim_id;
  logic          claim_rd;

  // source 0 never pends
  assign rise   = {i_irq[N-1:1] & ~irq_prev[N-1:1], 1'b0};
  assign active = pend_q & en_q;

  // lowest numbered active source wins
  always_comb begin
    claim_id = '0;
    for (int i = N - 1; i >= 1; i--) begin
      if (active[i]) begin
        claim_id = IW'(i);
      end
    end
  end

  // a claim read retires that source
  assign claim_rd  = i_req.rd && (i_req.offset == `SOC_PLIC_CLAIM);
  assign claim_clr = claim_rd ? (N'(1) << claim_id) : '0;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      irq_prev <= '0;
      pend_q   <= '0;
      en_q     <= '0;
      o_meip   <= 1'b0;
    end else begin
      irq_prev <= i_irq;
      pend_q   <= (pend_q | rise) & ~claim_clr;
      if (i_req.wr && (i_req.offset == `SOC_PLIC_ENABLE)) begin
        en_q <= i_req.wdata[N-1:0];
      end
      o_meip <= |active;
    end
  end

  // register read mux
  always_comb begin
    o_rdata = '0;
    if (i_req.rd) begin
      case (i_req.offset)
        `SOC_PLIC_PENDING: o_rdata = 32'(pend_q);
        `SOC_PLIC_ENABLE:  o_rdata = 32'(en_q);
        `SOC_PLIC_CLAIM:   o_rdata = 32'(claim_id);
        default:           o_rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/soc_top.sv ====
//////////////////////////////////////////////////
// soc top level
// host port queue, bus controller, reset block and
// the gpio, clint and plic peripherals
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module soc_top (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  // host port
  input  wire                    soc_pkg::host_req_t i_req,
  output logic                   o_req_full,
  output soc_pkg::bus_rsp_t      o_rsp,
  // gpio pins
  input  wire  [`SOC_GPIO_W-1:0] i_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio_dir,
  // interrupt lines
  output logic                   o_mtip,
  output logic                   o_msip,
  output logic                   o_meip
);

  logic                 sys_rst_n;
  logic                 swreset;
  soc_pkg::host_req_t   head;
  logic                 pop;
  soc_pkg::periph_req_t gpio_req;
  soc_pkg::periph_req_t clint_req;
  soc_pkg::periph_req_t plic_req;
  logic [31:0]          gpio_rdata;
  logic [31:0]          clint_rdata;
  logic [31:0]          plic_rdata;
  logic [`SOC_GPIO_W-1:0]   gpio_irq;
  logic [`SOC_IRQ_TOTAL-1:0] plic_src;

  // source 0 tied low, gpio on 1..12, rest unused
  assign plic_src = {{(`SOC_IRQ_TOTAL - `SOC_GPIO_W - 1){1'b0}}, gpio_irq, 1'b0};

  ////////////////////////////////////////////////
  // reset and host path
  reset_global rst0 (
    .i_clk,
    .i_rst_n,
    .i_swreset(swreset),
    .o_sys_rst_n(sys_rst_n)
  );

  // host path stays on external reset
  bus_req_fifo fifo0 (
    .i_clk,
    .i_rst_n,
    .i_req,
    .i_pop(pop),
    .o_head(head),
    .o_full(o_req_full)
  );

  bus_ctrl ctrl0 (
    .i_clk,
    .i_rst_n,
    .i_head(head),
    .o_pop(pop),
    .o_gpio_req(gpio_req),
    .o_clint_req(clint_req),
    .o_plic_req(plic_req),
    .i_gpio_rdata(gpio_rdata),
    .i_clint_rdata(clint_rdata),
    .i_plic_rdata(plic_rdata),
    .o_swreset(swreset),
    .o_rsp
  );

  ////////////////////////////////////////////////
  // peripherals on the system reset
  gpio_ctrl gpio0 (
    .i_clk,
    .i_rst_n(sys_rst_n),
    .i_req(gpio_req),
    .o_rdata(gpio_rdata),
    .i_gpio,
    .o_gpio,
    .o_gpio_dir,
    .o_irq(gpio_irq)
  );

  clint clint0 (
    .i_clk,
    .i_rst_n(sys_rst_n),
    .i_req(clint_req),
    .o_rdata(clint_rdata),
    .o_mtip,
    .o_msip
  );

  plic plic0 (
    .i_clk,
    .i_rst_n(sys_rst_n),
    .i_req(plic_req),
    .i_irq(plic_src),
    .o_rdata(plic_rdata),
    .o_meip
  );

endmodule

`default_nettype wire

// ==== test/tb_soc.sv ====
//////////////////////////////////////////////////
// soc testbench
// directed tests over the host port covering gpio,
// the gpio to plic interrupt path, clint, request
// queue ordering, decode errors and software reset
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module tb_soc;

  localparam int CLK_NS   = 10;
  localparam int RST_CYC  = 8;
  localparam int RSP_WAIT = 10;

  // cycle budgets per test
  // watchdog allows twice their sum
  localparam int BUD_RESET  = 20;
  localparam int BUD_GPIO   = 120;
  localparam int BUD_IRQ    = 200;
  localparam int BUD_CLINT  = 150;
  localparam int BUD_FIFO   = 120;
  localparam int BUD_DECODE = 60;
  localparam int BUD_SWRST  = 160;
  localparam int BUD_TOTAL  = BUD_RESET + BUD_GPIO + BUD_IRQ + BUD_CLINT +
                              BUD_FIFO + BUD_DECODE + BUD_SWRST;

  logic                    clk;
  logic                    rst_n;
  soc_pkg::host_req_t      req;
  logic                    req_full;
  soc_pkg::bus_rsp_t       rsp;
  logic [`SOC_GPIO_W-1:0]  gpio_in;
  logic [`SOC_GPIO_W-1:0]  gpio_out;
  logic [`SOC_GPIO_W-1:0]  gpio_dir;
  logic                    mtip;
  logic                    msip;
  logic                    meip;

  logic [15:0] lfsr_q;
  int          err_cnt;
  int          check_cnt;
  int          tests_run;

  soc_top dut0 (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_req(req),
    .o_req_full(req_full),
    .o_rsp(rsp),
    .i_gpio(gpio_in),
    .o_gpio(gpio_out),
    .o_gpio_dir(gpio_dir),
    .o_mtip(mtip),
    .o_msip(msip),
    .o_meip(meip)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_NS / 2) clk = ~clk;

  ////////////////////////////////////////////////
  // random data

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  ////////////////////////////////////////////////
  // address helpers and expectation model

  function automatic logic [11:0] addr_of(input logic [3:0] base, input logic [3:0] ofs);
    return {base, 4'h0, ofs};
  endfunction

  // region from address bits 11..8
  function automatic soc_pkg::region_e expect_region(input logic [11:0] addr);
    case (addr[11:8])
      `SOC_BASE_GPIO:  return soc_pkg::REG_GPIO;
      `SOC_BASE_CLINT: return soc_pkg::REG_CLINT;
      `SOC_BASE_PLIC:  return soc_pkg::REG_PLIC;
      `SOC_BASE_SYS:   return soc_pkg::REG_SYS;
      default:         return soc_pkg::REG_NONE;
    endcase
  endfunction

  // unmapped regions and unused sys offsets flag an error
  function automatic logic expect_err(input logic [11:0] addr);
    soc_pkg::region_e r;
    r = expect_region(addr);
    return (r == soc_pkg::REG_NONE) ||
           ((r == soc_pkg::REG_SYS) && (addr[3:0] != `SOC_SYS_SWRST));
  endfunction

  ////////////////////////////////////////////////
  // compare tasks

  task automatic cmp_rsp(input string name, input soc_pkg::bus_rsp_t exp,
                         input soc_pkg::bus_rsp_t act);
    check_cnt++;
    if (act.valid !== exp.valid || act.err !== exp.err || act.rdata !== exp.rdata) begin
      err_cnt++;
      $display("error %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic cmp_gpio(input string name, input logic [`SOC_GPIO_W-1:0] exp,
                          input logic [`SOC_GPIO_W-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("error %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic cmp_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("error %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////
  // host port tasks enter and leave 1 ns after an edge

  task automatic bus_access(input logic we, input logic [11:0] addr,
                            input logic [31:0] data, output soc_pkg::bus_rsp_t r);
    int                  n;
    logic                got;
    soc_pkg::bus_state_e st;
    n   = 0;
    got = 1'b0;
    r   = '0;
    req = '{valid: 1'b1, we: we, addr: addr, wdata: data};
    @(posedge clk);
    #1;
    req = '0;
    while (!got && n < RSP_WAIT) begin
      if (rsp.valid) begin
        got = 1'b1;
        r   = rsp;
      end else begin
        @(posedge clk);
        #1;
        n++;
      end
    end
    if (!got) begin
      st = dut0.ctrl0.state_q;
      err_cnt++;
      $display("no response within %0d cycles for address 0x%h, controller in %s",
               RSP_WAIT, addr, st.name());
    end
  endtask

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                           output soc_pkg::bus_rsp_t r);
    bus_access(1'b1, addr, data, r);
  endtask

  task automatic bus_read(input logic [11:0] addr, output soc_pkg::bus_rsp_t r);
    bus_access(1'b0, addr, 32'h0, r);
  endtask

  // write that must complete without error
  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    soc_pkg::bus_rsp_t r;
    bus_write(addr, data, r);
    cmp_bit("o_rsp.valid", 1'b1, r.valid);
    cmp_bit("o_rsp.err", 1'b0, r.err);
  endtask

  // read whose response must match exactly
  task automatic read_expect(input string name, input logic [11:0] addr,
                             input logic [31:0] data);
    soc_pkg::bus_rsp_t r;
    soc_pkg::bus_rsp_t exp;
    bus_read(addr, r);
    exp = '{valid: 1'b1, err: expect_err(addr), rdata: data};
    cmp_rsp(name, exp, r);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic test_done(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s had %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////
  // tests

  task automatic test_reset_values();
    int e0;
    e0 = err_cnt;
    cmp_bit("o_rsp.valid", 1'b0, rsp.valid);
    cmp_bit("o_req_full", 1'b0, req_full);
    cmp_gpio("o_gpio", '0, gpio_out);
    cmp_gpio("o_gpio_dir", '0, gpio_dir);
    cmp_bit("o_mtip", 1'b0, mtip);
    cmp_bit("o_msip", 1'b0, msip);
    cmp_bit("o_meip", 1'b0, meip);
    test_done("reset_values", e0);
  endtask

  task automatic test_gpio_regs();
    int          e0;
    logic [31:0] v_out;
    logic [31:0] v_dir;
    logic [31:0] v_in;
    e0 = err_cnt;
    take_bits(32, v_out);
    take_bits(32, v_dir);
    take_bits(`SOC_GPIO_W, v_in);
    write_reg(addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT), v_out);
    cmp_gpio("o_gpio", v_out[`SOC_GPIO_W-1:0], gpio_out);
    write_reg(addr_of(`SOC_BASE_GPIO, `SOC_GPIO_DIR), v_dir);
    cmp_gpio("o_gpio_dir", v_dir[`SOC_GPIO_W-1:0], gpio_dir);
    // registers are only gpio wide
    read_expect("gpio OUT", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT),
                32'(v_out[`SOC_GPIO_W-1:0]));
    read_expect("gpio DIR", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_DIR),
                32'(v_dir[`SOC_GPIO_W-1:0]));
    // input passes the synchronizer first
    gpio_in = v_in[`SOC_GPIO_W-1:0];
    wait_cycles(3);
    read_expect("gpio IN", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_IN), v_in);
    test_done("gpio_regs", e0);
  endtask

  task automatic test_gpio_irq();
    int          e0;
    int          k;
    int          n;
    logic [31:0] bits;
    e0 = err_cnt;
    take_bits(4, bits);
    k = int'(bits) % `SOC_GPIO_W;
    // all pins low so only pin k can see a rising edge
    gpio_in = '0;
    wait_cycles(4);
    write_reg(addr_of(`SOC_BASE_GPIO, `SOC_GPIO_IE), 32'(1) << k);
    write_reg(addr_of(`SOC_BASE_PLIC, `SOC_PLIC_ENABLE), 32'(1) << (k + 1));
    cmp_bit("o_meip", 1'b0, meip);
    gpio_in[k] = 1'b1;
    n = 0;
    while (!meip && n < 10) begin
      wait_cycles(1);
      n++;
    end
    cmp_bit("o_meip", 1'b1, meip);
    read_expect("gpio IP", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_IP), 32'(1) << k);
    // gpio pin k is plic source k + 1
    read_expect("plic CLAIM", addr_of(`SOC_BASE_PLIC, `SOC_PLIC_CLAIM), 32'(k + 1));
    wait_cycles(1);
    cmp_bit("o_meip", 1'b0, meip);
    read_expect("gpio IP", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_IP), 32'(1) << k);
    write_reg(addr_of(`SOC_BASE_GPIO, `SOC_GPIO_IP), 32'(1) << k);
    read_expect("gpio IP", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_IP), 32'h0);
    read_expect("plic CLAIM", addr_of(`SOC_BASE_PLIC, `SOC_PLIC_CLAIM), 32'h0);
    gpio_in = '0;
    test_done("gpio_irq", e0);
  endtask

  task automatic test_clint();
    int e0;
    int n;
    e0 = err_cnt;
    write_reg(addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MTIME), 32'd0);
    write_reg(addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MTIMECMP), 32'd20);
    cmp_bit("o_mtip", 1'b0, mtip);
    n = 0;
    while (!mtip && n < 25) begin
      wait_cycles(1);
      n++;
    end
    cmp_bit("o_mtip", 1'b1, mtip);
    write_reg(addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MTIMECMP), 32'hffff_ffff);
    wait_cycles(1);
    cmp_bit("o_mtip", 1'b0, mtip);
    write_reg(addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MSIP), 32'd1);
    cmp_bit("o_msip", 1'b1, msip);
    write_reg(addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MSIP), 32'd0);
    cmp_bit("o_msip", 1'b0, msip);
    test_done("clint", e0);
  endtask

  task automatic test_fifo_order();
    int          e0;
    int          issued;
    int          rsp_n;
    int          cyc;
    logic        seen_full;
    logic [31:0] wd [6];
    logic [11:0] wa [6];
    e0 = err_cnt;
    for (int i = 0; i < 6; i++) begin
      take_bits(32, wd[i]);
      wa[i] = (i % 2 == 0) ? addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT)
                           : addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MTIMECMP);
    end
    issued    = 0;
    rsp_n     = 0;
    cyc       = 0;
    seen_full = 1'b0;
    // response pulse of the previous access is still up
    wait_cycles(1);
    // strobe every cycle the queue has room and count responses meanwhile
    while ((issued < 6 || rsp_n < 6) && cyc < 60) begin
      if (rsp.valid) begin
        rsp_n++;
        cmp_bit("o_rsp.err", 1'b0, rsp.err);
      end
      if (req_full) begin
        seen_full = 1'b1;
      end
      if (issued < 6 && !req_full) begin
        req = '{valid: 1'b1, we: 1'b1, addr: wa[issued], wdata: wd[issued]};
        issued++;
      end else begin
        req = '0;
      end
      wait_cycles(1);
      cyc++;
    end
    req = '0;
    // nothing extra may follow
    repeat (8) begin
      if (rsp.valid) begin
        rsp_n++;
      end
      wait_cycles(1);
    end
    check_cnt++;
    if (!seen_full) begin
      err_cnt++;
      $display("request queue never reported full during back to back writes");
    end
    check_cnt++;
    if (rsp_n != 6) begin
      err_cnt++;
      $display("expected 6 responses to back to back writes, counted %0d", rsp_n);
    end
    read_expect("gpio OUT", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT),
                32'(wd[4][`SOC_GPIO_W-1:0]));
    read_expect("clint MTIMECMP", addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MTIMECMP), wd[5]);
    test_done("fifo_order", e0);
  endtask

  task automatic test_decode();
    int e0;
    e0 = err_cnt;
    // err flag comes from expect_err inside read_expect
    read_expect("region 3", addr_of(4'h3, 4'h0), 32'h0);
    read_expect("sys ofs 5", addr_of(`SOC_BASE_SYS, 4'h5), 32'h0);
    read_expect("sys SWRST", addr_of(`SOC_BASE_SYS, `SOC_SYS_SWRST), 32'h0);
    test_done("decode", e0);
  endtask

  task automatic test_swreset();
    int          e0;
    logic [31:0] v_out;
    e0 = err_cnt;
    take_bits(32, v_out);
    write_reg(addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT), v_out);
    write_reg(addr_of(`SOC_BASE_GPIO, `SOC_GPIO_DIR), 32'hfff);
    write_reg(addr_of(`SOC_BASE_PLIC, `SOC_PLIC_ENABLE), 32'h1ffe);
    write_reg(addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MTIMECMP), 32'h1234);
    // wrong key leaves everything alone
    write_reg(addr_of(`SOC_BASE_SYS, `SOC_SYS_SWRST), `SOC_SWRST_KEY ^ 32'h1);
    read_expect("gpio OUT", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT),
                32'(v_out[`SOC_GPIO_W-1:0]));
    write_reg(addr_of(`SOC_BASE_SYS, `SOC_SYS_SWRST), `SOC_SWRST_KEY);
    // host port answers while the peripherals are held in reset
    read_expect("gpio OUT", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT), 32'h0);
    wait_cycles(`SOC_RST_HOLD + 2);
    // peripherals back at reset values
    read_expect("gpio OUT", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_OUT), 32'h0);
    read_expect("gpio DIR", addr_of(`SOC_BASE_GPIO, `SOC_GPIO_DIR), 32'h0);
    read_expect("plic ENABLE", addr_of(`SOC_BASE_PLIC, `SOC_PLIC_ENABLE), 32'h0);
    read_expect("clint MTIMECMP", addr_of(`SOC_BASE_CLINT, `SOC_CLINT_MTIMECMP),
                32'hffff_ffff);
    cmp_gpio("o_gpio_dir", '0, gpio_dir);
    test_done("swreset", e0);
  endtask

  ////////////////////////////////////////////////
  // main sequence

  initial begin
    rst_n     = 1'b0;
    req       = '0;
    gpio_in   = '0;
    lfsr_q    = 16'd80;
    err_cnt   = 0;
    check_cnt = 0;
    tests_run = 0;
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // let the system reset follow
    wait_cycles(2);
    test_reset_values();
    test_gpio_regs();
    test_gpio_irq();
    test_clint();
    test_fifo_order();
    test_decode();
    test_swreset();
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(BUD_TOTAL * 2 * CLK_NS);
    $display("timeout, simulation still running after %0d cycles", BUD_TOTAL * 2);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/soc_pkg.sv
rtl/reset_global.sv
bus/bus_req_fifo.sv
bus/bus_ctrl.sv
rtl/gpio_ctrl.sv
rtl/clint.sv
rtl/plic.sv
rtl/soc_top.sv
test/tb_soc.sv
